// File: Makefile
TOP := tb_mem_subsys

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f rtl/*.sv test/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only rtl/axi_pkg.sv rtl/axi_arbiter.sv rtl/axi_sram.sv \
		rtl/mem_subsys.sv --top-module mem_subsys
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: compile.f
rtl/axi_pkg.sv
rtl/axi_arbiter.sv
rtl/axi_sram.sv
rtl/mem_subsys.sv
test/tb_clkgen.sv
test/tb_mem_subsys.sv

// File: rtl/axi_arbiter.sv
`timescale 1ns/100ps

module axi_arbiter (
    input  logic             clk,
    input  logic             rst_n,

    // fetch master, read only
    input  axi_pkg::axi_ar_t if_ar,
    input  logic             if_ar_valid,
    output logic             if_ar_ready,
    output axi_pkg::axi_r_t  if_r,
    output logic             if_r_valid,
    input  logic             if_r_ready,

    // load/store master
    input  axi_pkg::axi_ar_t ls_ar,
    input  logic             ls_ar_valid,
    output logic             ls_ar_ready,
    input  axi_pkg::axi_aw_t ls_aw,
    input  logic             ls_aw_valid,
    output logic             ls_aw_ready,
    input  axi_pkg::axi_w_t  ls_w,
    input  logic             ls_w_valid,
    output logic             ls_w_ready,
    output axi_pkg::axi_r_t  ls_r,
    output logic             ls_r_valid,
    input  logic             ls_r_ready,
    output axi_pkg::axi_b_t  ls_b,
    output logic             ls_b_valid,
    input  logic             ls_b_ready,

    // toward the slave
    output axi_pkg::axi_ar_t s_ar,
    output logic             s_ar_valid,
    input  logic             s_ar_ready,
    output axi_pkg::axi_aw_t s_aw,
    output logic             s_aw_valid,
    input  logic             s_aw_ready,
    output axi_pkg::axi_w_t  s_w,
    output logic             s_w_valid,
    input  logic             s_w_ready,
    input  axi_pkg::axi_r_t  s_r,
    input  logic             s_r_valid,
    output logic             s_r_ready,
    input  axi_pkg::axi_b_t  s_b,
    input  logic             s_b_valid,
    output logic             s_b_ready
);

    axi_pkg::arb_state_e state;

    logic owner_ls;     // 1 = load/store holds the slave
    logic last_ls;      // last completed grant
    logic is_idle;
    logic is_busy;
    logic if_req;
    logic ls_req;
    logic grant_ls;
    logic sel_ls;
    logic req_hs;
    logic rsp_hs;

    assign is_idle = (state == axi_pkg::arb_idle);
    assign is_busy = (state == axi_pkg::arb_busy);

    assign if_req = if_ar_valid;
    assign ls_req = ls_ar_valid || (ls_aw_valid && ls_w_valid);

    // round robin, the other master wins a tie
    assign grant_ls = ls_req && (!if_req || !last_ls);
    assign sel_ls   = is_idle ? grant_ls : owner_ls;

    // request channels pass through in the grant cycle
    assign s_ar       = sel_ls ? ls_ar : if_ar;
    assign s_ar_valid = is_idle && (sel_ls ? ls_ar_valid : if_ar_valid);
    assign s_aw       = ls_aw;
    assign s_aw_valid = is_idle && sel_ls && ls_aw_valid;
    assign s_w        = ls_w;
    assign s_w_valid  = is_idle && sel_ls && ls_w_valid;

    assign if_ar_ready = is_idle && !sel_ls && s_ar_ready;
    assign ls_ar_ready = is_idle && (sel_ls || !if_req) && s_ar_ready;   // ready while fetch is quiet
    assign ls_aw_ready = is_idle && (sel_ls || !if_req) && s_aw_ready;
    assign ls_w_ready  = is_idle && (sel_ls || !if_req) && s_w_ready;

    // responses go back to the owner only
    assign if_r       = s_r;
    assign ls_r       = s_r;
    assign ls_b       = s_b;
    assign if_r_valid = is_busy && !owner_ls && s_r_valid;
    assign ls_r_valid = is_busy && owner_ls && s_r_valid;
    assign ls_b_valid = is_busy && owner_ls && s_b_valid;
    assign s_r_ready  = is_busy && (owner_ls ? ls_r_ready : if_r_ready);
    assign s_b_ready  = is_busy && owner_ls && ls_b_ready;

    assign req_hs = (s_ar_valid && s_ar_ready)
                 || (s_aw_valid && s_aw_ready && s_w_valid && s_w_ready);
    assign rsp_hs = (s_r_valid && s_r_ready) || (s_b_valid && s_b_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= axi_pkg::arb_idle;
            owner_ls <= 1'b0;
            last_ls  <= 1'b0;   // fetch counts as last grant
        end else begin
            case (state)
                axi_pkg::arb_idle: begin
                    if (req_hs) begin
                        state    <= axi_pkg::arb_busy;
                        owner_ls <= sel_ls;
                    end
                end
                axi_pkg::arb_busy: begin
                    if (rsp_hs) begin
                        state   <= axi_pkg::arb_idle;
                        last_ls <= owner_ls;
                    end
                end
                default: state <= axi_pkg::arb_idle;
            endcase
        end
    end

    // slave response reaches one master at most
    assert property (@(posedge clk) disable iff (!rst_n) !(if_r_valid && ls_r_valid))
        else $error("axi_arbiter: read response routed to both masters");

endmodule

// File: rtl/axi_pkg.sv
package axi_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;   // one strobe per byte

    // read data after reset
    localparam logic [data_w-1:0] nop_word = 32'h0000_0013;   // addi x0, x0, 0

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } axi_resp_e;

    // read address channel
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_ar_t;

    // write address channel
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axi_w_t;

    // read response channel
    typedef struct packed {
        logic [data_w-1:0] data;
        axi_resp_e         resp;
    } axi_r_t;

    // write response channel
    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    // memory slave FSM
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_read      = 3'd1,
        st_write     = 3'd2,
        st_err_read  = 3'd3,   // out of window, answer at once
        st_err_write = 3'd4
    } sram_state_e;

    // arbiter FSM
    typedef enum logic {
        arb_idle = 1'b0,
        arb_busy = 1'b1
    } arb_state_e;

endpackage

// File: rtl/axi_sram.sv
`timescale 1ns/100ps

module axi_sram #(
    parameter logic [axi_pkg::addr_w-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int                         MEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst_n,

    input  axi_pkg::axi_ar_t ar,
    input  logic             ar_valid,
    output logic             ar_ready,

    input  axi_pkg::axi_aw_t aw,
    input  logic             aw_valid,
    output logic             aw_ready,

    input  axi_pkg::axi_w_t  w,
    input  logic             w_valid,
    output logic             w_ready,

    output axi_pkg::axi_r_t  r,
    output logic             r_valid,
    input  logic             r_ready,

    output axi_pkg::axi_b_t  b,
    output logic             b_valid,
    input  logic             b_ready
);

    localparam int idx_w = $clog2(MEM_WORDS);
    localparam logic [axi_pkg::addr_w-1:0] win_bytes = MEM_WORDS * 4;

    axi_pkg::sram_state_e state;
    axi_pkg::sram_state_e state_nxt;

    logic [axi_pkg::data_w-1:0] mem [MEM_WORDS];

    logic [axi_pkg::addr_w-1:0] addr_q;
    logic [axi_pkg::data_w-1:0] wdata_q;
    logic [axi_pkg::strb_w-1:0] wstrb_q;

    logic [2:0] lfsr;       // delay source
    logic [2:0] wait_cnt;

    logic                       rd_take;
    logic                       wr_take;
    logic                       ar_hit;
    logic                       aw_hit;
    logic                       cnt_match;
    logic                       mem_rd_fire;
    logic                       mem_wr_fire;
    logic [axi_pkg::addr_w-1:0] addr_off;
    logic [idx_w-1:0]           word_idx;

    function automatic logic in_window(input logic [axi_pkg::addr_w-1:0] a);
        logic [axi_pkg::addr_w-1:0] off;
        off = a - MEM_BASE;
        return (a >= MEM_BASE) && (off < win_bytes);
    endfunction

    assign ar_ready = (state == axi_pkg::st_idle);
    assign aw_ready = (state == axi_pkg::st_idle);
    assign w_ready  = (state == axi_pkg::st_idle);

    // read wins over write in the same idle cycle
    assign rd_take = (state == axi_pkg::st_idle) && ar_valid;
    assign wr_take = (state == axi_pkg::st_idle) && !ar_valid && aw_valid && w_valid;
    assign ar_hit  = in_window(ar.addr);
    assign aw_hit  = in_window(aw.addr);

    assign cnt_match   = (wait_cnt == lfsr);
    assign mem_rd_fire = (state == axi_pkg::st_read) && !r_valid && cnt_match;
    assign mem_wr_fire = (state == axi_pkg::st_write) && !b_valid && cnt_match;

    assign addr_off = addr_q - MEM_BASE;
    assign word_idx = addr_off[idx_w+1:2];   // byte offset bits dropped

    always_comb begin
        state_nxt = state;
        case (state)
            axi_pkg::st_idle: begin
                if (rd_take) begin
                    state_nxt = ar_hit ? axi_pkg::st_read : axi_pkg::st_err_read;
                end else if (wr_take) begin
                    state_nxt = aw_hit ? axi_pkg::st_write : axi_pkg::st_err_write;
                end
            end
            axi_pkg::st_read, axi_pkg::st_err_read: begin
                if (r_valid && r_ready) begin
                    state_nxt = axi_pkg::st_idle;
                end
            end
            axi_pkg::st_write, axi_pkg::st_err_write: begin
                if (b_valid && b_ready) begin
                    state_nxt = axi_pkg::st_idle;
                end
            end
            default: state_nxt = axi_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= axi_pkg::st_idle;
            lfsr     <= 3'b001;
            wait_cnt <= 3'd0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
            r.data   <= axi_pkg::nop_word;
            r.resp   <= axi_pkg::resp_okay;
            b.resp   <= axi_pkg::resp_okay;
        end else begin
            state <= state_nxt;

            if (state == axi_pkg::st_idle) begin
                lfsr     <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};   // x^3 + x^2 + 1
                wait_cnt <= 3'd0;
            end else if (!r_valid && !b_valid) begin
                wait_cnt <= cnt_match ? 3'd0 : wait_cnt + 3'd1;
            end

            if (rd_take && !ar_hit) begin
                r_valid <= 1'b1;
                r.data  <= '0;
                r.resp  <= axi_pkg::resp_decerr;
            end else if (mem_rd_fire) begin
                r_valid <= 1'b1;
                r.data  <= mem[word_idx];
                r.resp  <= axi_pkg::resp_okay;
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end

            if (wr_take && !aw_hit) begin
                b_valid <= 1'b1;
                b.resp  <= axi_pkg::resp_decerr;
            end else if (mem_wr_fire) begin
                b_valid <= 1'b1;
                b.resp  <= axi_pkg::resp_okay;
            end else if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (rd_take) begin
            addr_q <= ar.addr;
        end else if (wr_take) begin
            addr_q  <= aw.addr;
            wdata_q <= w.data;
            wstrb_q <= w.strb;
        end
    end

    // byte merge
    always_ff @(posedge clk) begin
        if (mem_wr_fire) begin
            for (int i = 0; i < axi_pkg::strb_w; i++) begin
                if (wstrb_q[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata_q[8*i +: 8];
                end
            end
        end
    end

    // one response channel active at a time
    assert property (@(posedge clk) disable iff (!rst_n) !(r_valid && b_valid))
        else $error("axi_sram: r_valid and b_valid high together");

    // read response held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else $error("axi_sram: read response changed before r_ready");

endmodule

// File: rtl/mem_subsys.sv
`timescale 1ns/100ps

module mem_subsys #(
    parameter logic [axi_pkg::addr_w-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int                         MEM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst_n,

    // fetch master
    input  axi_pkg::axi_ar_t if_ar,
    input  logic             if_ar_valid,
    output logic             if_ar_ready,
    output axi_pkg::axi_r_t  if_r,
    output logic             if_r_valid,
    input  logic             if_r_ready,

    // load/store master
    input  axi_pkg::axi_ar_t ls_ar,
    input  logic             ls_ar_valid,
    output logic             ls_ar_ready,
    input  axi_pkg::axi_aw_t ls_aw,
    input  logic             ls_aw_valid,
    output logic             ls_aw_ready,
    input  axi_pkg::axi_w_t  ls_w,
    input  logic             ls_w_valid,
    output logic             ls_w_ready,
    output axi_pkg::axi_r_t  ls_r,
    output logic             ls_r_valid,
    input  logic             ls_r_ready,
    output axi_pkg::axi_b_t  ls_b,
    output logic             ls_b_valid,
    input  logic             ls_b_ready
);

    // arbiter to slave
    axi_pkg::axi_ar_t s_ar;
    axi_pkg::axi_aw_t s_aw;
    axi_pkg::axi_w_t  s_w;
    axi_pkg::axi_r_t  s_r;
    axi_pkg::axi_b_t  s_b;
    logic s_ar_valid, s_ar_ready;
    logic s_aw_valid, s_aw_ready;
    logic s_w_valid, s_w_ready;
    logic s_r_valid, s_r_ready;
    logic s_b_valid, s_b_ready;

    axi_arbiter arbiter_i (
        .clk         (clk),         .rst_n       (rst_n),
        .if_ar       (if_ar),       .if_ar_valid (if_ar_valid), .if_ar_ready (if_ar_ready),
        .if_r        (if_r),        .if_r_valid  (if_r_valid),  .if_r_ready  (if_r_ready),
        .ls_ar       (ls_ar),       .ls_ar_valid (ls_ar_valid), .ls_ar_ready (ls_ar_ready),
        .ls_aw       (ls_aw),       .ls_aw_valid (ls_aw_valid), .ls_aw_ready (ls_aw_ready),
        .ls_w        (ls_w),        .ls_w_valid  (ls_w_valid),  .ls_w_ready  (ls_w_ready),
        .ls_r        (ls_r),        .ls_r_valid  (ls_r_valid),  .ls_r_ready  (ls_r_ready),
        .ls_b        (ls_b),        .ls_b_valid  (ls_b_valid),  .ls_b_ready  (ls_b_ready),
        .s_ar        (s_ar),        .s_ar_valid  (s_ar_valid),  .s_ar_ready  (s_ar_ready),
        .s_aw        (s_aw),        .s_aw_valid  (s_aw_valid),  .s_aw_ready  (s_aw_ready),
        .s_w         (s_w),         .s_w_valid   (s_w_valid),   .s_w_ready   (s_w_ready),
        .s_r         (s_r),         .s_r_valid   (s_r_valid),   .s_r_ready   (s_r_ready),
        .s_b         (s_b),         .s_b_valid   (s_b_valid),   .s_b_ready   (s_b_ready)
    );

    axi_sram #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) sram_i (
        .clk      (clk),        .rst_n    (rst_n),
        .ar       (s_ar),       .ar_valid (s_ar_valid), .ar_ready (s_ar_ready),
        .aw       (s_aw),       .aw_valid (s_aw_valid), .aw_ready (s_aw_ready),
        .w        (s_w),        .w_valid  (s_w_valid),  .w_ready  (s_w_ready),
        .r        (s_r),        .r_valid  (s_r_valid),  .r_ready  (s_r_ready),
        .b        (s_b),        .b_valid  (s_b_valid),  .b_ready  (s_b_ready)
    );

endmodule

// File: test/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int half_period = 5,
    parameter int rst_cycles  = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;   // released on an edge, sync reset
    end

endmodule

// File: test/tb_mem_subsys.sv
`timescale 1ns/100ps

module tb_mem_subsys;

    localparam logic [31:0] mem_base  = 32'h8000_0000;
    localparam int          mem_words = 64;
    localparam int          req_timeout = 50;
    localparam int          rsp_timeout = 50;

    logic             clk;
    logic             rst_n;
    axi_pkg::axi_ar_t if_ar;
    logic             if_ar_valid;
    logic             if_ar_ready;
    axi_pkg::axi_r_t  if_r;
    logic             if_r_valid;
    logic             if_r_ready;
    axi_pkg::axi_ar_t ls_ar;
    logic             ls_ar_valid;
    logic             ls_ar_ready;
    axi_pkg::axi_aw_t ls_aw;
    logic             ls_aw_valid;
    logic             ls_aw_ready;
    axi_pkg::axi_w_t  ls_w;
    logic             ls_w_valid;
    logic             ls_w_ready;
    axi_pkg::axi_r_t  ls_r;
    logic             ls_r_valid;
    logic             ls_r_ready;
    axi_pkg::axi_b_t  ls_b;
    logic             ls_b_valid;
    logic             ls_b_ready;

    int          seed;
    int          stall_mask;
    int          checks;
    int          errors;
    int          timeouts;
    logic [31:0] model [int];   // word index -> expected contents
    int          grants [$];    // 0 fetch, 1 load/store
    int          last_grant;

    tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

    mem_subsys #(
        .MEM_BASE  (mem_base),
        .MEM_WORDS (mem_words)
    ) mem_subsys_i (.*);

    function automatic logic [31:0] word_addr(input int idx);
        return mem_base + 32'(idx * 4);
    endfunction

    function automatic int word_of(input logic [31:0] a);
        return int'((a - mem_base) >> 2);
    endfunction

    function automatic bit addr_in_window(input logic [31:0] a);
        return (a >= mem_base) && ((a - mem_base) < 32'(mem_words * 4));
    endfunction

    function automatic int rand_index();
        return int'({$random(seed)} % mem_words);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // chan 0 = fetch read, 1 = load/store read, 2 = load/store write
    function automatic logic req_ready(input int chan);
        case (chan)
            0:       return if_ar_ready;
            1:       return ls_ar_ready;
            default: return ls_aw_ready && ls_w_ready;
        endcase
    endfunction

    function automatic logic rsp_valid(input int chan);
        case (chan)
            0:       return if_r_valid;
            1:       return ls_r_valid;
            default: return ls_b_valid;
        endcase
    endfunction

    function automatic logic rsp_ready(input int chan);
        case (chan)
            0:       return if_r_ready;
            1:       return ls_r_ready;
            default: return ls_b_ready;
        endcase
    endfunction

    function automatic logic [33:0] rsp_payload(input int chan);
        case (chan)
            0:       return {if_r.data, if_r.resp};
            1:       return {ls_r.data, ls_r.resp};
            default: return {32'h0, ls_b.resp};
        endcase
    endfunction

    task automatic set_ready(input int chan, input logic val);
        case (chan)
            0:       if_r_ready <= val;
            1:       ls_r_ready <= val;
            default: ls_b_ready <= val;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // returns at the handshake edge
    task automatic wait_accept(input int chan, input string name, output bit ok);
        int cnt;
        cnt = 0;
        ok = 0;
        while (!ok && cnt < req_timeout) begin
            @(negedge clk);
            cnt++;
            ok = req_ready(chan);
        end
        if (ok) begin
            last_grant = (chan == 0) ? 0 : 1;
            grants.push_back(last_grant);
        end else begin
            timeouts++;
            $display("timeout at %0t: %s never went high", $time, name);
        end
        @(posedge clk);
    endtask

    task automatic wait_resp(input int chan, input string name, output logic [31:0] data,
                             output axi_pkg::axi_resp_e resp, output bit ok);
        int          cnt;
        int          stall;
        bit          held;
        logic [33:0] first;
        logic [33:0] now_p;
        cnt = 0;
        held = 0;
        ok = 0;
        first = '0;
        now_p = '0;
        stall = $random(seed) & stall_mask;
        set_ready(chan, stall == 0);
        while (!ok && cnt < rsp_timeout) begin
            @(negedge clk);
            cnt++;
            now_p = rsp_payload(chan);
            if (rsp_valid(chan)) begin
                if (held && now_p !== first) begin
                    errors++;
                    $display("[FAIL] t=%0t %s: got %h, expected %h (changed while stalled)",
                             $time, name, now_p, first);
                end
                held = 1;
                first = now_p;
                if (rsp_ready(chan)) begin
                    ok = 1;
                end else if (stall > 0) begin
                    stall--;
                end
            end
            if (!ok) begin
                @(posedge clk);
                set_ready(chan, stall == 0);
            end
        end
        data = now_p[33:2];
        resp = axi_pkg::axi_resp_e'(now_p[1:0]);
        if (!ok) begin
            timeouts++;
            $display("timeout at %0t: no %s response within %0d cycles", $time, name, cnt);
        end else begin
            @(posedge clk);
            set_ready(chan, 1'b0);
            @(negedge clk);
            if (rsp_valid(chan)) begin
                errors++;
                $display("%s response still valid after its handshake at %0t", name, $time);
            end
        end
    endtask

    task automatic check_read(input string name, input logic [31:0] addr,
                              input logic [31:0] data, input axi_pkg::axi_resp_e resp);
        logic [31:0] exp_data;
        axi_pkg::axi_resp_e exp_resp;
        exp_data = '0;   // decode error reads zero
        exp_resp = axi_pkg::resp_decerr;
        if (addr_in_window(addr)) begin
            exp_data = model[word_of(addr)];
            exp_resp = axi_pkg::resp_okay;
        end
        check_value({name, ".resp"}, 32'(resp), 32'(exp_resp));
        check_value({name, ".data"}, data, exp_data);
    endtask

    task automatic if_read(input logic [31:0] addr);
        logic [31:0] data;
        axi_pkg::axi_resp_e resp;
        bit ok;
        @(posedge clk);
        if_ar.addr  <= addr;
        if_ar_valid <= 1'b1;
        wait_accept(0, "if_ar_ready", ok);
        if_ar_valid <= 1'b0;
        if (ok) begin
            wait_resp(0, "if_r", data, resp, ok);
            if (ok) begin
                check_read("if_r", addr, data, resp);
            end
        end
    endtask

    task automatic ls_read(input logic [31:0] addr);
        logic [31:0] data;
        axi_pkg::axi_resp_e resp;
        bit ok;
        @(posedge clk);
        ls_ar.addr  <= addr;
        ls_ar_valid <= 1'b1;
        wait_accept(1, "ls_ar_ready", ok);
        ls_ar_valid <= 1'b0;
        if (ok) begin
            wait_resp(1, "ls_r", data, resp, ok);
            if (ok) begin
                check_read("ls_r", addr, data, resp);
            end
        end
    endtask

    task automatic ls_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [31:0] unused;
        logic [31:0] old_w;
        axi_pkg::axi_resp_e resp;
        axi_pkg::axi_resp_e exp_resp;
        bit ok;
        @(posedge clk);
        ls_aw.addr  <= addr;
        ls_w.data   <= data;
        ls_w.strb   <= strb;
        ls_aw_valid <= 1'b1;
        ls_w_valid  <= 1'b1;
        wait_accept(2, "ls_aw_ready and ls_w_ready", ok);
        ls_aw_valid <= 1'b0;
        ls_w_valid  <= 1'b0;
        if (ok) begin
            wait_resp(2, "ls_b", unused, resp, ok);
            if (ok) begin
                exp_resp = axi_pkg::resp_decerr;
                if (addr_in_window(addr)) begin
                    exp_resp = axi_pkg::resp_okay;
                    old_w = model.exists(word_of(addr)) ? model[word_of(addr)] : '0;
                    model[word_of(addr)] = merge_bytes(old_w, data, strb);
                end
                check_value("ls_b.resp", 32'(resp), 32'(exp_resp));
            end
        end
    endtask

    task automatic reset_state_test();
        @(negedge clk);
        check_value("if_ar_ready", 32'(if_ar_ready), 32'd1);
        check_value("ls_ar_ready", 32'(ls_ar_ready), 32'd1);
        check_value("ls_aw_ready", 32'(ls_aw_ready), 32'd1);
        check_value("ls_w_ready", 32'(ls_w_ready), 32'd1);
        check_value("if_r_valid", 32'(if_r_valid), 32'd0);
        check_value("ls_r_valid", 32'(ls_r_valid), 32'd0);
        check_value("ls_b_valid", 32'(ls_b_valid), 32'd0);
        check_value("ls_r.data", ls_r.data, 32'h0000_0013);   // riscv nop
    endtask

    task automatic rw_test();
        int idx;
        for (int i = 0; i < mem_words; i++) begin
            ls_write(word_addr(i), $random(seed), 4'hf);   // every word known from here
        end
        for (int i = 0; i < 20; i++) begin
            idx = rand_index();
            ls_write(word_addr(idx), $random(seed), 4'hf);
            ls_read(word_addr(idx));
        end
    endtask

    task automatic strobe_test();
        int idx;
        for (int i = 0; i < 16; i++) begin
            idx = rand_index();
            ls_write(word_addr(idx), $random(seed), 4'($random(seed)));
            ls_read(word_addr(idx));
            if_read(word_addr(idx));
        end
    endtask

    task automatic decode_test();
        logic [31:0] bad [4];
        bad[0] = mem_base - 32'd4;
        bad[1] = 32'h0000_0000;
        bad[2] = mem_base + 32'(mem_words * 4);   // first byte past the window
        bad[3] = mem_base + 32'(mem_words * 4) + 32'h100;
        foreach (bad[i]) begin
            ls_read(bad[i]);
            if_read(bad[i]);
            ls_write(bad[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < mem_words; i++) begin
            ls_read(word_addr(i));
        end
    endtask

    task automatic contention_test();
        int expect_first;
        for (int k = 0; k < 8; k++) begin
            expect_first = (last_grant == 0) ? 1 : 0;
            grants.delete();
            fork
                if_read(word_addr(k));
                if (k % 2 == 0) begin
                    ls_read(word_addr(k + 32));
                end else begin
                    ls_write(word_addr(k + 32), $random(seed), 4'hf);
                end
            join
            check_value("grant count", 32'(grants.size()), 32'd2);
            if (grants.size() == 2) begin
                check_value("first grant", 32'(grants[0]), 32'(expect_first));
                check_value("second grant", 32'(grants[1]), 32'(1 - expect_first));
            end
        end
    endtask

    task automatic backpressure_test();
        int idx;
        int op;
        stall_mask = 15;   // longer ready stalls
        for (int i = 0; i < 24; i++) begin
            idx = rand_index();
            op = int'({$random(seed)} % 3);
            if (op == 0) begin
                ls_write(word_addr(idx), $random(seed), 4'($random(seed)));
            end else if (op == 1) begin
                ls_read(word_addr(idx));
            end else begin
                if_read(word_addr(idx));
            end
        end
        stall_mask = 7;
    endtask

    always @(negedge clk) begin
        if (rst_n && if_r_valid && (ls_r_valid || ls_b_valid)) begin
            errors++;
            $display("responses to both masters valid together at %0t", $time);
        end
    end

    initial begin
        int cnt;
        seed = 85767;
        stall_mask = 7;
        checks = 0;
        errors = 0;
        timeouts = 0;
        last_grant = 0;
        if_ar       <= '0;
        if_ar_valid <= 1'b0;
        if_r_ready  <= 1'b0;
        ls_ar       <= '0;
        ls_ar_valid <= 1'b0;
        ls_aw       <= '0;
        ls_aw_valid <= 1'b0;
        ls_w        <= '0;
        ls_w_valid  <= 1'b0;
        ls_r_ready  <= 1'b0;
        ls_b_ready  <= 1'b0;
        cnt = 0;
        while (rst_n !== 1'b1 && cnt < 100) begin
            @(posedge clk);
            cnt++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout: reset never released");
        end else begin
            reset_state_test();
            rw_test();
            strobe_test();
            decode_test();
            contention_test();
            backpressure_test();
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
